//--- build.f
+incdir+include
hw/gpioPkg.sv
hw/outputRegister.sv
hw/inputRegister.sv
hw/gpioDevice.sv
tb/gpioDevice_properties.sv
tb/gpioDevice_tb.sv

//--- hw/gpioDevice.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpio_settings.svh"

module gpioDevice
	import gpioPkg::*;
#(
	parameter deviceId_t ID = 4'h0
) (
	input logic clk,
	input logic rstN,

	input logic peripheralEnable,
	input logic we,
	input logic oe,
	input busAddr_t busAddress,
	input byteSel_t byteSelect,
	input busData_t dataWrite,
	output busData_t dataRead,
	output logic requestOutput,

	input pinVector_t gpioInput,
	output pinVector_t gpioOutput,
	output pinVector_t gpioOe
);

	deviceId_t addressId;
	logic deviceEnable;
	localAddr_t localAddress;

	busData_t oeData;
	logic oeRequest;
	busData_t outData;
	logic outRequest;
	busData_t inputData;
	logic inputRequest;

	// top nibble picks the device.
	assign addressId = busAddress[15:12];
	assign deviceEnable = peripheralEnable && (addressId == ID);
	assign localAddress = busAddress[11:0];

	outputRegister #(
		.ADDRESS(`GPIO_ADDR_OE),
		.RESET_VALUE(`GPIO_OE_RESET)
	) oeRegister (
		.clk(clk),
		.rstN(rstN),
		.enable(deviceEnable),
		.we(we),
		.oe(oe),
		.localAddress(localAddress),
		.byteSelect(byteSelect),
		.dataWrite(dataWrite),
		.dataRead(oeData),
		.requestOutput(oeRequest),
		.currentValue(gpioOe)
	);

	outputRegister #(
		.ADDRESS(`GPIO_ADDR_OUT),
		.RESET_VALUE(`GPIO_OUT_RESET)
	) dataOutRegister (
		.clk(clk),
		.rstN(rstN),
		.enable(deviceEnable),
		.we(we),
		.oe(oe),
		.localAddress(localAddress),
		.byteSelect(byteSelect),
		.dataWrite(dataWrite),
		.dataRead(outData),
		.requestOutput(outRequest),
		.currentValue(gpioOutput)
	);

	// serves both 0x020 and 0x024.
	inputRegister pinInput (
		.clk(clk),
		.rstN(rstN),
		.enable(deviceEnable),
		.we(we),
		.oe(oe),
		.localAddress(localAddress),
		.byteSelect(byteSelect),
		.dataWrite(dataWrite),
		.dataRead(inputData),
		.requestOutput(inputRequest),
		.pins(gpioInput)
	);

	assign requestOutput = oeRequest || outRequest || inputRequest;

	// only one register answers a given read.
	always_comb begin
		if (oeRequest) begin
			dataRead = oeData;
		end else if (outRequest) begin
			dataRead = outData;
		end else if (inputRequest) begin
			dataRead = inputData;
		end else begin
			dataRead = '1; // idle bus.
		end
	end

endmodule

`default_nettype wire

//--- hw/gpioPkg.sv
`default_nettype none

`include "gpio_settings.svh"

package gpioPkg;

	typedef logic [15:0] busAddr_t; // full bus address.
	typedef logic [11:0] localAddr_t; // offset inside one device.
	typedef logic [31:0] busData_t;
	typedef logic [3:0] byteSel_t;
	typedef logic [3:0] deviceId_t;
	typedef logic [`GPIO_IO_COUNT-1:0] pinVector_t;

	localparam int PIN_COUNT = `GPIO_IO_COUNT;

	// expand byte selects to one bit per pin.
	function automatic pinVector_t laneMask(input byteSel_t byteSelect);
		pinVector_t mask;
		for (int i = 0; i < PIN_COUNT; i++) begin
			mask[i] = byteSelect[i / 8];
		end
		return mask;
	endfunction

	// pin vector onto the bus, upper bits zero.
	function automatic busData_t zeroExtend(input pinVector_t value);
		return busData_t'(value);
	endfunction

endpackage

`default_nettype wire

//--- hw/inputRegister.sv
`timescale 1ns/10ps
`default_nettype none

`include "gpio_settings.svh"

module inputRegister
	import gpioPkg::*;
(
	input logic clk,
	input logic rstN,

	input logic enable,
	input logic we,
	input logic oe,
	input localAddr_t localAddress,
	input byteSel_t byteSelect,
	input busData_t dataWrite,
	output busData_t dataRead,
	output logic requestOutput,

	input pinVector_t pins
);

	localparam int SYNC_STAGES = `GPIO_SYNC_STAGES;
	localparam localAddr_t INPUT_ADDRESS = `GPIO_ADDR_IN;
	localparam localAddr_t EDGE_ADDRESS = `GPIO_ADDR_EDGE;

	logic inputRead;
	logic edgeRead;
	logic edgeWrite;
	pinVector_t syncStages [SYNC_STAGES];
	pinVector_t syncValue;
	pinVector_t previousValue;
	pinVector_t risingEdges;
	pinVector_t clearMask;
	pinVector_t capture;
	pinVector_t readValue;

	assign inputRead = enable && oe && (localAddress == INPUT_ADDRESS);
	assign edgeRead = enable && oe && (localAddress == EDGE_ADDRESS);
	assign edgeWrite = enable && we && (localAddress == EDGE_ADDRESS);

	// pad synchronizer, plus one more flop for edge detection.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < SYNC_STAGES; i++) begin
				syncStages[i] <= '0;
			end
			previousValue <= '0;
		end else begin
			syncStages[0] <= pins;
			for (int i = 1; i < SYNC_STAGES; i++) begin
				syncStages[i] <= syncStages[i - 1];
			end
			previousValue <= syncValue;
		end
	end

	assign syncValue = syncStages[SYNC_STAGES - 1];
	assign risingEdges = syncValue & ~previousValue;

	// write one to clear, per selected byte.
	assign clearMask = edgeWrite ? (dataWrite[PIN_COUNT-1:0] & laneMask(byteSelect)) : '0;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			capture <= '0;
		end else begin
			capture <= (capture & ~clearMask) | risingEdges; // new edge beats the clear.
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			requestOutput <= 1'b0;
		end else begin
			requestOutput <= inputRead || edgeRead;
		end
	end

	always_ff @(posedge clk) begin
		if (inputRead) begin
			readValue <= syncValue;
		end else if (edgeRead) begin
			readValue <= capture;
		end
	end

	assign dataRead = zeroExtend(readValue);

endmodule

`default_nettype wire

//--- hw/outputRegister.sv
`timescale 1ns/10ps
`default_nettype none

module outputRegister
	import gpioPkg::*;
#(
	parameter localAddr_t ADDRESS = 12'h000,
	parameter pinVector_t RESET_VALUE = '0
) (
	input logic clk,
	input logic rstN,

	input logic enable,
	input logic we,
	input logic oe,
	input localAddr_t localAddress,
	input byteSel_t byteSelect,
	input busData_t dataWrite,
	output busData_t dataRead,
	output logic requestOutput,

	output pinVector_t currentValue
);

	logic addressMatch;
	logic writeMatch;
	logic readMatch;
	pinVector_t writeMask;
	pinVector_t writeBits;
	pinVector_t value;
	pinVector_t readValue;

	assign addressMatch = enable && (localAddress == ADDRESS);
	assign writeMatch = addressMatch && we;
	assign readMatch = addressMatch && oe;

	// bytes above the pin count fall off here.
	assign writeMask = laneMask(byteSelect);
	assign writeBits = dataWrite[PIN_COUNT-1:0];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			value <= RESET_VALUE;
		end else if (writeMatch) begin
			value <= (value & ~writeMask) | (writeBits & writeMask);
		end
	end

	// response goes out one cycle after the read.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			requestOutput <= 1'b0;
		end else begin
			requestOutput <= readMatch;
		end
	end

	always_ff @(posedge clk) begin
		if (readMatch) begin
			readValue <= value; // value before any same-cycle write.
		end
	end

	assign dataRead = zeroExtend(readValue);
	assign currentValue = value; // pins follow the register.

endmodule

`default_nettype wire

//--- include/gpio_settings.svh
`ifndef GPIO_SETTINGS_SVH
`define GPIO_SETTINGS_SVH

// number of pins on the port.
`define GPIO_IO_COUNT 16

// register offsets within the device window.
`define GPIO_ADDR_OE 12'h000
`define GPIO_ADDR_OUT 12'h004
`define GPIO_ADDR_IN 12'h020
`define GPIO_ADDR_EDGE 12'h024

// pins come up as outputs driving low.
`define GPIO_OE_RESET {`GPIO_IO_COUNT{1'b1}}
`define GPIO_OUT_RESET {`GPIO_IO_COUNT{1'b0}}

// flops between the pad and the input register.
`define GPIO_SYNC_STAGES 2

`endif

//--- runSim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM=gpioSim

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --assert --top-module gpioDevice_tb -f build.f \
	--Mdir "$BUILD_DIR" -o "$SIM"
status=$?
if [ $status -ne 0 ]; then
	echo "runSim: compile failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "runSim: simulator exited with status $status"
	exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
	echo "runSim: pass"
	exit 0
else
	echo "runSim: fail, see $LOG"
	exit 1
fi

//--- tb/gpioDevice_properties.sv
`timescale 1ns/10ps
`default_nettype none

module gpioDevice_properties
	import gpioPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic deviceEnable,
	input logic oe,
	input logic oeRequest,
	input logic outRequest,
	input logic inputRequest,
	input logic requestOutput,
	input busData_t dataRead
);

	logic readAccess;

	assign readAccess = deviceEnable && oe; // read aimed at this device.

	responseFollowsRead: assert property (@(posedge clk) disable iff (!rstN)
		requestOutput |-> $past(readAccess))
		else $error("requestOutput without a device read in the cycle before");

	// one register answers at a time.
	singleRequester: assert property (@(posedge clk) disable iff (!rstN)
		$onehot0({oeRequest, outRequest, inputRequest}))
		else $error("more than one register request active");

	idleData: assert property (@(posedge clk) disable iff (!rstN)
		!requestOutput |-> dataRead == '1)
		else $error("dataRead not all ones while idle");

	singlePulse: assert property (@(posedge clk) disable iff (!rstN)
		$past(readAccess) && !readAccess |=> !requestOutput)
		else $error("requestOutput still high two cycles after a single read");

endmodule

bind gpioDevice gpioDevice_properties props (
	.clk(clk),
	.rstN(rstN),
	.deviceEnable(deviceEnable),
	.oe(oe),
	.oeRequest(oeRequest),
	.outRequest(outRequest),
	.inputRequest(inputRequest),
	.requestOutput(requestOutput),
	.dataRead(dataRead)
);

`default_nettype wire

//--- tb/gpioDevice_tb.sv
`timescale 1ns/10ps
`default_nettype none

module gpioDevice_tb
	import gpioPkg::*;
();

	localparam deviceId_t DEVICE_ID = 4'h3;
	localparam int READ_TIMEOUT = 4;
	localparam int PIN_SETTLE = 4; // synchronizer, edge flop and capture.
	localparam int RANDOM_ROUNDS = 8;

	logic clk;
	logic rstN;
	logic peripheralEnable;
	logic we;
	logic oe;
	busAddr_t busAddress;
	byteSel_t byteSelect;
	busData_t dataWrite;
	busData_t dataRead;
	logic requestOutput;
	pinVector_t gpioInput;
	pinVector_t gpioOutput;
	pinVector_t gpioOe;

	int passCount;
	int failCount;
	int groupErrors;
	int groupNumber;
	integer seed;
	busAddr_t readAddrs[$];
	busData_t readExpected[$];

	gpioDevice #(.ID(DEVICE_ID)) uut (
		.clk(clk),
		.rstN(rstN),
		.peripheralEnable(peripheralEnable),
		.we(we),
		.oe(oe),
		.busAddress(busAddress),
		.byteSelect(byteSelect),
		.dataWrite(dataWrite),
		.dataRead(dataRead),
		.requestOutput(requestOutput),
		.gpioInput(gpioInput),
		.gpioOutput(gpioOutput),
		.gpioOe(gpioOe)
	);

	always #20 clk = ~clk;

	task automatic checkValue(input string name, input busData_t actual, input busData_t expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h",
				$time, name, actual, expected);
			failCount++;
			groupErrors++;
		end else begin
			passCount++;
		end
	endtask

	task automatic countFailure();
		failCount++;
		groupErrors++;
	endtask

	task automatic finishGroup();
		if (groupNumber >= 0) begin
			$display("test group %0d done with %0d errors", groupNumber, groupErrors);
		end
	endtask

	task automatic startGroup(input int number);
		finishGroup();
		groupNumber = number;
		groupErrors = 0;
	endtask

	// called right after a posedge.
	task automatic idleBus();
		peripheralEnable <= 1'b0;
		we <= 1'b0;
		oe <= 1'b0;
		busAddress <= '0;
		byteSelect <= '0;
		dataWrite <= '0;
	endtask

	task automatic writeWord(input busAddr_t addr, input byteSel_t sel, input busData_t data);
		@(posedge clk);
		peripheralEnable <= 1'b1;
		we <= 1'b1;
		oe <= 1'b0;
		busAddress <= addr;
		byteSelect <= sel;
		dataWrite <= data;
		@(posedge clk); // write lands here.
		idleBus();
	endtask

	task automatic applyPins(input pinVector_t value);
		@(posedge clk);
		gpioInput <= value;
		repeat (PIN_SETTLE) @(posedge clk);
	endtask

	// all queued reads go out on consecutive cycles.
	task automatic issueReads();
		int total;
		int received;
		int cycle;
		total = readAddrs.size();
		received = 0;
		cycle = 0;
		while (received < total && cycle < total + READ_TIMEOUT) begin
			@(posedge clk);
			if (cycle < total) begin
				peripheralEnable <= 1'b1;
				oe <= 1'b1;
				we <= 1'b0;
				busAddress <= readAddrs[cycle];
				byteSelect <= 4'hf;
			end else begin
				idleBus();
			end
			@(negedge clk);
			if (requestOutput) begin
				checkValue($sformatf("dataRead for %h", readAddrs[received]), dataRead,
					readExpected[received]);
				received++;
			end
			cycle++;
		end
		@(posedge clk);
		idleBus();
		if (received < total) begin
			$display("got %0d of %0d read responses, the rest timed out after %0d cycles",
				received, total, READ_TIMEOUT);
			countFailure();
		end
		readAddrs.delete();
		readExpected.delete();
	endtask

	task automatic probeNoResponse(input busAddr_t addr, input busData_t idleValue);
		logic pulseSeen;
		pulseSeen = 1'b0;
		@(posedge clk);
		peripheralEnable <= 1'b1;
		oe <= 1'b1;
		we <= 1'b0;
		busAddress <= addr;
		@(posedge clk);
		idleBus();
		for (int cycle = 0; cycle < READ_TIMEOUT; cycle++) begin
			@(negedge clk);
			if (requestOutput) begin
				pulseSeen = 1'b1;
			end
			checkValue("dataRead", dataRead, idleValue);
		end
		if (pulseSeen) begin
			$display("a read of address %h answered although nothing should", addr);
			countFailure();
		end
	endtask

	task automatic checkPins(input busData_t expectOut, input busData_t expectOe);
		@(negedge clk);
		checkValue("gpioOutput", busData_t'(gpioOutput), expectOut);
		checkValue("gpioOe", busData_t'(gpioOe), expectOe);
	endtask

	task automatic runOperation(input logic [7:0] opChar, input logic [31:0] addrField,
		input logic [31:0] selField, input logic [31:0] dataField, input logic [31:0] expectField);
		case (opChar)
			"G": startGroup(int'(addrField));
			"W": writeWord(addrField[15:0], selField[3:0], dataField);
			"B": begin
				readAddrs.push_back(addrField[15:0]);
				readExpected.push_back(expectField);
			end
			"R": begin
				readAddrs.push_back(addrField[15:0]);
				readExpected.push_back(expectField);
				issueReads();
			end
			"P": applyPins(pinVector_t'(dataField));
			"X": probeNoResponse(addrField[15:0], expectField);
			"O": checkPins(dataField, expectField);
			default: begin
				$display("unknown operation %s in the test file", opChar);
				countFailure();
			end
		endcase
	endtask

	task automatic runTestFile();
		int fd;
		int code;
		logic done;
		logic [7:0] opChar;
		logic [31:0] addrField;
		logic [31:0] selField;
		logic [31:0] dataField;
		logic [31:0] expectField;
		logic [8*160-1:0] lineText;
		fd = $fopen("tb/gpioTests.txt", "r");
		if (fd == 0) begin
			$display("could not open tb/gpioTests.txt");
			countFailure();
		end else begin
			done = 1'b0;
			while (!done) begin
				code = $fscanf(fd, " %c", opChar);
				if (code != 1) begin
					done = 1'b1;
				end else if (opChar == "#") begin
					code = $fgets(lineText, fd); // skip the comment.
				end else begin
					code = $fscanf(fd, " %h %h %h %h", addrField, selField, dataField, expectField);
					if (code != 4) begin
						$display("malformed line in the test file after operation %s", opChar);
						countFailure();
						done = 1'b1;
					end else begin
						runOperation(opChar, addrField, selField, dataField, expectField);
					end
				end
			end
			$fclose(fd);
			if (readAddrs.size() > 0) begin
				issueReads();
			end
		end
	endtask

	task automatic runRandomPins();
		integer randomValue;
		for (int round = 0; round < RANDOM_ROUNDS; round++) begin
			randomValue = $random(seed);
			applyPins(pinVector_t'(randomValue));
			readAddrs.push_back({DEVICE_ID, 12'h020});
			readExpected.push_back(busData_t'(pinVector_t'(randomValue)));
			issueReads();
		end
	endtask

	// every pin falls while the capture register is clear.
	task automatic checkFallingEdges();
		busAddr_t edgeAddress;
		edgeAddress = {DEVICE_ID, 12'h024};
		applyPins('1);
		writeWord(edgeAddress, 4'hf, '1);
		applyPins('0);
		readAddrs.push_back(edgeAddress);
		readExpected.push_back(32'h0);
		issueReads();
	endtask

	initial begin
		clk = 1'b0;
		seed = 69464;
		passCount = 0;
		failCount = 0;
		groupErrors = 0;
		groupNumber = -1;
		rstN <= 1'b0;
		gpioInput <= '0;
		idleBus();
		repeat (4) @(posedge clk);
		rstN <= 1'b1;

		startGroup(0);
		@(negedge clk);
		checkValue("requestOutput", busData_t'(requestOutput), 32'h0);
		checkValue("dataRead", dataRead, 32'hffffffff);

		runTestFile();
		startGroup(7);
		runRandomPins();
		startGroup(8);
		checkFallingEdges();
		finishGroup();

		$display("checks passed: %0d, checks failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/gpioTests.txt
# columns: op address byteSelect data expected, all hex
# ops: G group, W write, R read, B queued read, P pins=data, X no response, O pins out=data oe=expected
G 1 0 0 0
O 0 0 00000000 0000ffff
X 5000 f 00000000 ffffffff
R 3000 f 00000000 0000ffff
R 3004 f 00000000 00000000
G 2 0 0 0
W 3004 1 0000a5c3 0
R 3004 f 00000000 000000c3
O 0 0 000000c3 0000ffff
W 3004 2 12345678 0
R 3004 f 00000000 000056c3
W 3000 2 00000000 0
R 3000 f 00000000 000000ff
O 0 0 000056c3 000000ff
W 3000 c ffffffff 0
R 3000 f 00000000 000000ff
W 3004 3 ffff1234 0
O 0 0 00001234 000000ff
R 3004 f 00000000 00001234
G 3 0 0 0
P 0 0 0000a55a 0
R 3020 f 00000000 0000a55a
P 0 0 0000ffff 0
R 3020 f 00000000 0000ffff
P 0 0 00000000 0
R 3020 f 00000000 00000000
G 4 0 0 0
W 3024 3 0000ffff 0
R 3024 f 00000000 00000000
P 0 0 000000f0 0
R 3024 f 00000000 000000f0
P 0 0 00000000 0
R 3024 f 00000000 000000f0
P 0 0 00000f00 0
R 3024 f 00000000 00000ff0
W 3024 f 00000030 0
R 3024 f 00000000 00000fc0
W 3024 1 00000f00 0
R 3024 f 00000000 00000fc0
W 3024 2 00000f00 0
R 3024 f 00000000 000000c0
R 3020 f 00000000 00000f00
G 5 0 0 0
X 5004 f 00000000 ffffffff
X 3008 f 00000000 ffffffff
X 3100 f 00000000 ffffffff
W 5004 f 0000ffff 0
W 2000 f 00000000 0
O 0 0 00001234 000000ff
R 3004 f 00000000 00001234
G 6 0 0 0
B 3000 f 00000000 000000ff
B 3004 f 00000000 00001234
B 3020 f 00000000 00000f00
R 3024 f 00000000 000000c0
B 3004 f 00000000 00001234
R 3004 f 00000000 00001234
